// File: mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

////////////////////////////////////////////////////////////
// Data memory geometry
////////////////////////////////////////////////////////////

`define MEM_DEPTH     256  // Number of 32-bit words
`define DATA_W        32   // Word width
`define WORD_ADDR_W   8    // log2(MEM_DEPTH)
`define BYTE_ADDR_W   10   // Word address plus two offset bits

////////////////////////////////////////////////////////////
// Request queue
////////////////////////////////////////////////////////////

// Entries in the queue, also the requester's starting credits
`define REQ_DEPTH     4

`endif

// File: mem_access_pkg.sv
`include "mem_config.svh"

// Types for a pipeline load or store
package mem_access_pkg;

  // Access width as decoded by the MIPS load opcodes
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,  // LB / LBU
    SIZE_HALF = 2'd1,  // LH / LHU
    SIZE_WORD = 2'd2   // LW / SW
  } access_size_t;

  // Read word seen as byte lanes or as halfword lanes
  // Lane 0 is the least significant one (little endian)
  typedef union packed {
    logic [`DATA_W/8-1:0][7:0]   bytes;   // Four byte lanes
    logic [`DATA_W/16-1:0][15:0] halves;  // Two halfword lanes
  } read_word_u;

endpackage

// File: mem_scrub_pkg.sv
// Types for the scrub walk over the data memory
package mem_scrub_pkg;

  // Walker phases
  // IDLE  normal accesses are served
  // WALK  pointer steps over every word, one per cycle
  // DRAIN last rewrite lands, then one quiet cycle
  typedef enum logic [1:0] {
    SCRUB_IDLE  = 2'd0,
    SCRUB_WALK  = 2'd1,
    SCRUB_DRAIN = 2'd2
  } scrub_phase_t;

endpackage

// File: req_queue.sv
`timescale 1ns/1ns
`include "mem_config.svh"

// Credit-managed request FIFO between pipeline and data memory
module req_queue import mem_access_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rsta,
  input  logic                    i_req_valid,     // Costs one credit
  input  logic                    i_req_write,     // 1 = store word
  input  access_size_t            i_req_size,
  input  logic                    i_req_unsigned,  // Zero extend on load
  input  logic [`BYTE_ADDR_W-1:0] i_req_addr,
  input  logic [`DATA_W-1:0]      i_req_wdata,
  input  logic                    i_hold,          // Scrub running or starting
  output logic                    o_pop,           // Access strobe to memory
  output logic                    o_write,         // Store strobe, only with o_pop
  output logic [`WORD_ADDR_W-1:0] o_word_addr,
  output logic [`DATA_W-1:0]      o_wdata,
  output access_size_t            o_size,
  output logic                    o_unsigned,
  output logic [1:0]              o_offset,
  output logic                    o_credit         // One credit back per pop
);

  localparam int PTR_W = $clog2(`REQ_DEPTH);
  localparam int CNT_W = $clog2(`REQ_DEPTH + 1);

  // Entry storage
  logic                    q_write    [`REQ_DEPTH];
  access_size_t            q_size     [`REQ_DEPTH];
  logic                    q_unsigned [`REQ_DEPTH];
  logic [`BYTE_ADDR_W-1:0] q_addr     [`REQ_DEPTH];
  logic [`DATA_W-1:0]      q_wdata    [`REQ_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             pop_go;

  assign pop_go = (count != '0) && !i_hold;

  ////////////////////////////////////////////////////////////
  // Pointers, occupancy, strobes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      o_pop    <= 1'b0;
      o_write  <= 1'b0;
      o_credit <= 1'b0;
    end else begin
      if (i_req_valid)
        wr_ptr <= (wr_ptr == PTR_W'(`REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop_go)
        rd_ptr <= (rd_ptr == PTR_W'(`REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count    <= count + CNT_W'(i_req_valid) - CNT_W'(pop_go);
      o_pop    <= pop_go;
      o_write  <= pop_go && q_write[rd_ptr];  // Qualified store strobe
      o_credit <= o_pop;                      // Credit trails the pop by a cycle
    end
  end

  // Payload, no reset needed
  always_ff @(posedge i_clk) begin
    if (i_req_valid) begin
      q_write[wr_ptr]    <= i_req_write;
      q_size[wr_ptr]     <= i_req_size;
      q_unsigned[wr_ptr] <= i_req_unsigned;
      q_addr[wr_ptr]     <= i_req_addr;
      q_wdata[wr_ptr]    <= i_req_wdata;
    end
    if (pop_go) begin
      o_word_addr <= q_addr[rd_ptr][`BYTE_ADDR_W-1:2];  // Drop byte offset
      o_offset    <= q_addr[rd_ptr][1:0];
      o_wdata     <= q_wdata[rd_ptr];
      o_size      <= q_size[rd_ptr];
      o_unsigned  <= q_unsigned[rd_ptr];
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Requester sent without a credit
  a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rsta)
    i_req_valid |-> (count != CNT_W'(`REQ_DEPTH)));

  // Only aligned whole-word stores are supported
  a_store_aligned: assert property (@(posedge i_clk) disable iff (i_rsta)
    (i_req_valid && i_req_write) |-> (i_req_addr[1:0] == 2'b00));

endmodule

// File: data_memory.sv
`timescale 1ns/1ns
`include "mem_config.svh"

// Single-port no-change block RAM with a software scrub walker
module data_memory import mem_scrub_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rsta,
  input  logic                    i_ena,          // Port enable from the queue
  input  logic                    i_wea,          // Write, else read
  input  logic [`WORD_ADDR_W-1:0] i_addr,
  input  logic [`DATA_W-1:0]      i_data,
  input  logic                    i_scrub_start,  // One-cycle software pulse
  input  logic                    i_dirty,        // Dirty bit at o_scrub_addr
  output logic [`DATA_W-1:0]      o_data,         // Registered read word
  output logic                    o_scrub_busy,
  output logic [`WORD_ADDR_W-1:0] o_scrub_addr,   // Walk pointer to the tracker
  output logic                    o_scrub_clear   // Tracker clears this word
);

  logic [`DATA_W-1:0] mem [`MEM_DEPTH];
  logic [`DATA_W-1:0] rd_data;

  scrub_phase_t            phase;
  logic [`WORD_ADDR_W-1:0] scrub_ptr;
  logic                    wb_act;    // Walk stage one cycle behind
  logic                    wb_dirty;  // Lagged word needs rewrite
  logic [`WORD_ADDR_W-1:0] wb_addr;   // Lagged pointer

  // Power-up pattern is each word's own index
  initial begin
    for (int i = 0; i < `MEM_DEPTH; i++) begin
      mem[i] = `DATA_W'(i);
    end
  end

  ////////////////////////////////////////////////////////////
  // RAM port
  ////////////////////////////////////////////////////////////

  // Rewrite and access are never in the same cycle
  always_ff @(posedge i_clk) begin
    if (wb_dirty) begin
      mem[wb_addr] <= {{(`DATA_W - `WORD_ADDR_W){1'b0}}, wb_addr};  // Back to index
    end else if (i_ena) begin
      if (i_wea)
        mem[i_addr] <= i_data;  // Read register keeps its value
      else
        rd_data <= mem[i_addr];
    end
  end

  assign o_data = rd_data;  // Fixed one-cycle latency

  ////////////////////////////////////////////////////////////
  // Scrub walker
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      phase     <= SCRUB_IDLE;
      scrub_ptr <= '0;
      wb_act    <= 1'b0;
      wb_dirty  <= 1'b0;
    end else begin
      wb_act   <= (phase == SCRUB_WALK);
      wb_dirty <= o_scrub_clear;  // Rewrite one cycle after the lookup
      case (phase)
        SCRUB_IDLE: begin
          if (i_scrub_start) begin
            phase     <= SCRUB_WALK;
            scrub_ptr <= '0;
          end
        end
        SCRUB_WALK: begin
          if (scrub_ptr == `WORD_ADDR_W'(`MEM_DEPTH - 1))
            phase <= SCRUB_DRAIN;  // Last word looked up
          else
            scrub_ptr <= scrub_ptr + 1'b1;
        end
        SCRUB_DRAIN: begin
          if (!wb_act) phase <= SCRUB_IDLE;  // Last rewrite done, one quiet cycle
        end
        default: phase <= SCRUB_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    wb_addr <= scrub_ptr;
  end

  assign o_scrub_addr  = scrub_ptr;
  assign o_scrub_clear = (phase == SCRUB_WALK) && i_dirty;
  assign o_scrub_busy  = (phase != SCRUB_IDLE);  // MEM_DEPTH+2 cycles

  // Queue must hold off every access for the whole scrub
  a_no_access_busy: assert property (@(posedge i_clk) disable iff (i_rsta)
    o_scrub_busy |-> !i_ena);

  // Software starts a scrub only from idle
  a_no_restart: assert property (@(posedge i_clk) disable iff (i_rsta)
    i_scrub_start |-> !o_scrub_busy);

endmodule

// File: dirty_tracker.sv
`timescale 1ns/1ns
`include "mem_config.svh"

// One dirty bit per data word, set on stores and cleared by the scrub
module dirty_tracker (
  input  logic                    i_clk,
  input  logic                    i_rsta,
  input  logic                    i_set,         // Store strobe
  input  logic [`WORD_ADDR_W-1:0] i_set_addr,    // Stored word
  input  logic [`WORD_ADDR_W-1:0] i_scrub_addr,  // Walk pointer
  input  logic                    i_clear,       // Scrub rewrote this word
  output logic                    o_dirty        // Bit at the walk pointer
);

  logic [`MEM_DEPTH-1:0] dirty_q;  // All clean after reset

  ////////////////////////////////////////////////////////////
  // Bit vector update
  ////////////////////////////////////////////////////////////

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      dirty_q <= '0;
    end else begin
      if (i_set)
        dirty_q[i_set_addr] <= 1'b1;    // Word differs from its index
      if (i_clear)
        dirty_q[i_scrub_addr] <= 1'b0;  // Scrubbed back to index
    end
  end

  // Combinational lookup for the walker
  assign o_dirty = dirty_q[i_scrub_addr];

  // Stores are held in the queue for the whole scrub, so no store
  // may meet a clear from the walker
  a_set_clear_excl: assert property (@(posedge i_clk) disable iff (i_rsta)
    !(i_set && i_clear));

endmodule

// File: load_formatter.sv
`timescale 1ns/1ns
`include "mem_config.svh"

// Picks and extends the loaded lane, registers the response
module load_formatter import mem_access_pkg::*; (
  input  logic               i_clk,
  input  logic               i_rsta,
  input  logic               i_load,      // Load popped this cycle
  input  access_size_t       i_size,
  input  logic               i_unsigned,
  input  logic [1:0]         i_offset,    // Byte offset in the word
  input  logic [`DATA_W-1:0] i_word,      // Memory read word
  output logic               o_resp_valid,
  output logic [`DATA_W-1:0] o_resp_data
);

  // Tag delayed to line up with the memory read
  logic         load_q;
  access_size_t size_q;
  logic         unsigned_q;
  logic [1:0]   offset_q;

  read_word_u         word_u;
  logic [7:0]         sel_byte;
  logic [15:0]        sel_half;
  logic [`DATA_W-1:0] ext_data;

  always_ff @(posedge i_clk) begin
    if (i_rsta) begin
      load_q       <= 1'b0;
      o_resp_valid <= 1'b0;
    end else begin
      load_q       <= i_load;
      o_resp_valid <= load_q;  // No back-pressure on responses
    end
  end

  always_ff @(posedge i_clk) begin
    size_q     <= i_size;
    unsigned_q <= i_unsigned;
    offset_q   <= i_offset;
    o_resp_data <= ext_data;
  end

  ////////////////////////////////////////////////////////////
  // Lane select and extension
  ////////////////////////////////////////////////////////////

  always_comb begin
    word_u   = i_word;
    sel_byte = word_u.bytes[offset_q];      // Lane 0 at bits 7:0
    sel_half = word_u.halves[offset_q[1]];  // Upper half at offset 2
    case (size_q)
      SIZE_BYTE: ext_data = unsigned_q ? {{(`DATA_W - 8){1'b0}}, sel_byte}
                                       : {{(`DATA_W - 8){sel_byte[7]}}, sel_byte};
      SIZE_HALF: ext_data = unsigned_q ? {{(`DATA_W - 16){1'b0}}, sel_half}
                                       : {{(`DATA_W - 16){sel_half[15]}}, sel_half};
      default:   ext_data = word_u;  // Whole word as read
    endcase
  end

endmodule

// File: mem_stage_top.sv
`timescale 1ns/1ns
`include "mem_config.svh"

// MIPS memory stage: request queue, data memory, dirty tracker, formatter
module mem_stage_top import mem_access_pkg::*; (
  input  logic                    i_clk,
  input  logic                    i_rsta,
  input  logic                    i_req_valid,
  input  logic                    i_req_write,
  input  access_size_t            i_req_size,
  input  logic                    i_req_unsigned,
  input  logic [`BYTE_ADDR_W-1:0] i_req_addr,
  input  logic [`DATA_W-1:0]      i_req_wdata,
  input  logic                    i_scrub_start,
  output logic                    o_credit,
  output logic                    o_resp_valid,
  output logic [`DATA_W-1:0]      o_resp_data,
  output logic                    o_scrub_busy
);

  // Queue outputs
  logic                    pop;
  logic                    write;
  logic [`WORD_ADDR_W-1:0] word_addr;
  logic [`DATA_W-1:0]      wdata;
  access_size_t            size;
  logic                    is_unsigned;
  logic [1:0]              offset;

  // Memory and tracker links
  logic [`DATA_W-1:0]      rd_word;
  logic [`WORD_ADDR_W-1:0] scrub_addr;
  logic                    scrub_clear;
  logic                    dirty;
  logic                    queue_hold;
  logic                    load;

  assign queue_hold = o_scrub_busy | i_scrub_start;  // No pop into the first walk cycle
  assign load       = pop & ~write;                  // Stores give no response

  req_queue u_req_queue (
    .i_clk          (i_clk),
    .i_rsta         (i_rsta),
    .i_req_valid    (i_req_valid),
    .i_req_write    (i_req_write),
    .i_req_size     (i_req_size),
    .i_req_unsigned (i_req_unsigned),
    .i_req_addr     (i_req_addr),
    .i_req_wdata    (i_req_wdata),
    .i_hold         (queue_hold),
    .o_pop          (pop),
    .o_write        (write),
    .o_word_addr    (word_addr),
    .o_wdata        (wdata),
    .o_size         (size),
    .o_unsigned     (is_unsigned),
    .o_offset       (offset),
    .o_credit       (o_credit)
  );

  data_memory u_data_memory (
    .i_clk         (i_clk),
    .i_rsta        (i_rsta),
    .i_ena         (pop),
    .i_wea         (write),
    .i_addr        (word_addr),
    .i_data        (wdata),
    .i_scrub_start (i_scrub_start),
    .i_dirty       (dirty),
    .o_data        (rd_word),
    .o_scrub_busy  (o_scrub_busy),
    .o_scrub_addr  (scrub_addr),
    .o_scrub_clear (scrub_clear)
  );

  dirty_tracker u_dirty_tracker (
    .i_clk        (i_clk),
    .i_rsta       (i_rsta),
    .i_set        (write),
    .i_set_addr   (word_addr),
    .i_scrub_addr (scrub_addr),
    .i_clear      (scrub_clear),
    .o_dirty      (dirty)
  );

  load_formatter u_load_formatter (
    .i_clk        (i_clk),
    .i_rsta       (i_rsta),
    .i_load       (load),
    .i_size       (size),
    .i_unsigned   (is_unsigned),
    .i_offset     (offset),
    .i_word       (rd_word),
    .o_resp_valid (o_resp_valid),
    .o_resp_data  (o_resp_data)
  );

endmodule

// File: tb_mem_stage.sv
`timescale 1ns/1ns
`include "mem_config.svh"

module tb_mem_stage import mem_access_pkg::*;;

  localparam int TIMEOUT_CYCLES = 5000;  // Tests need ~1500 cycles incl. two scrubs

  logic                    i_clk;
  logic                    i_rsta;
  logic                    i_req_valid;
  logic                    i_req_write;
  access_size_t            i_req_size;
  logic                    i_req_unsigned;
  logic [`BYTE_ADDR_W-1:0] i_req_addr;
  logic [`DATA_W-1:0]      i_req_wdata;
  logic                    i_scrub_start;
  logic                    o_credit;
  logic                    o_resp_valid;
  logic [`DATA_W-1:0]      o_resp_data;
  logic                    o_scrub_busy;

  logic [`DATA_W-1:0] model [`MEM_DEPTH];  // Reference memory
  logic [`DATA_W-1:0] exp_q [$];           // Expected load data, request order
  int credits;       // Requester credits
  int sent;          // Requests issued
  int credit_pulses; // o_credit pulses seen
  int busy_cycles;   // Busy length of the last scrub
  int errors;
  int checks;
  int cycles;
  logic [31:0]        rnd;
  logic [1:0]         off;
  access_size_t       sz;

  mem_stage_top i_dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // Lane pick and extension from the MIPS load rules
  function automatic logic [31:0] expect_load(input logic [9:0] addr, input access_size_t s,
                                              input logic uns);
    logic [31:0] w;
    logic [7:0]  b;
    logic [15:0] h;
    w = model[addr[9:2]];
    b = w[8*addr[1:0] +: 8];   // Lane 0 is bits 7:0
    h = w[16*addr[1] +: 16];
    if (s == SIZE_BYTE) return uns ? {24'h0, b} : {{24{b[7]}}, b};
    if (s == SIZE_HALF) return uns ? {16'h0, h} : {{16{h[15]}}, h};
    return w;
  endfunction

  task automatic step();
    @(posedge i_clk);
    #10;
  endtask

  // One request, waits for a credit first
  task automatic send_req(input logic wr, input access_size_t s, input logic uns,
                          input logic [9:0] addr, input logic [31:0] wd);
    while (credits == 0) step();
    i_req_valid    = 1'b1;
    i_req_write    = wr;
    i_req_size     = s;
    i_req_unsigned = uns;
    i_req_addr     = addr;
    i_req_wdata    = wd;
    credits--;
    sent++;
    if (wr) model[addr[9:2]] = wd;
    else exp_q.push_back(expect_load(addr, s, uns));
    step();
    i_req_valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (credits < `REQ_DEPTH || exp_q.size() != 0) step();
  endtask

  // Queue is drained first, so every word the model holds gets scrubbed
  task automatic run_scrub();
    for (int i = 0; i < `MEM_DEPTH; i++) model[i] = 32'(i);
    busy_cycles   = 0;
    i_scrub_start = 1'b1;
    step();
    i_scrub_start = 1'b0;
    check_val("o_scrub_busy", o_scrub_busy, 1);
  endtask

  task automatic wait_scrub();
    while (o_scrub_busy) step();
    check_val("scrub busy cycles", busy_cycles, `MEM_DEPTH + 2);
  endtask

  ////////////////////////////////////////////////////////////
  // Monitors, sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge i_clk) begin
    if (!i_rsta) begin
      if (o_credit) begin
        credits++;
        credit_pulses++;
      end
      if (o_scrub_busy) busy_cycles++;
      if (o_resp_valid && o_scrub_busy) begin
        errors++;
        $display("Error at %0t ns: load response while a scrub is running", $time);
      end
      if (o_resp_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Error at %0t ns: response with no load outstanding", $time);
        end else begin
          check_val("o_resp_data", o_resp_data, exp_q.pop_front());
        end
      end
    end
  end

  // Watchdog
  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("checks=%0d errors=%0d", checks, errors + 1);
      $display("=== FAIL ===");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////

  initial begin
    i_rsta         = 1'b1;
    i_req_valid    = 1'b0;
    i_req_write    = 1'b0;
    i_req_size     = SIZE_WORD;
    i_req_unsigned = 1'b0;
    i_req_addr     = '0;
    i_req_wdata    = '0;
    i_scrub_start  = 1'b0;
    credits        = `REQ_DEPTH;
    sent           = 0;
    credit_pulses  = 0;
    busy_cycles    = 0;
    errors         = 0;
    checks         = 0;
    cycles         = 0;
    rnd = $urandom(35);  // Seed once
    for (int i = 0; i < `MEM_DEPTH; i++) model[i] = 32'(i);  // Power-up index pattern
    repeat (2) @(posedge i_clk);
    #10 i_rsta = 1'b0;

    // 1 reset state, burst of REQ_DEPTH loads
    check_val("o_credit", o_credit, 0);
    check_val("o_resp_valid", o_resp_valid, 0);
    check_val("o_scrub_busy", o_scrub_busy, 0);
    for (int i = 0; i < `REQ_DEPTH; i++) send_req(0, SIZE_WORD, 0, 10'(4 * i + 400), 0);
    wait_drain();
    check_val("credits returned", credit_pulses, sent);

    // 2 store then load, mixed with untouched words
    send_req(1, SIZE_WORD, 0, 10'h010, 32'hDEAD_BEEF);
    send_req(0, SIZE_WORD, 0, 10'h010, 0);
    send_req(1, SIZE_WORD, 0, 10'h3FC, 32'h1234_5678);
    send_req(0, SIZE_WORD, 0, 10'h014, 0);
    send_req(0, SIZE_WORD, 0, 10'h3FC, 0);
    wait_drain();

    // 3 every lane, signed and unsigned
    send_req(1, SIZE_WORD, 0, 10'h040, 32'h8A7F_C301);
    send_req(1, SIZE_WORD, 0, 10'h044, 32'h7FFF_8000);
    for (int u = 0; u < 2; u++) begin
      for (int o = 0; o < 4; o++) send_req(0, SIZE_BYTE, u[0], 10'(10'h040 + o), 0);
      for (int o = 0; o < 4; o += 2) begin
        send_req(0, SIZE_HALF, u[0], 10'(10'h040 + o), 0);
        send_req(0, SIZE_HALF, u[0], 10'(10'h044 + o), 0);
      end
    end
    wait_drain();

    // 4 scrub restores stored words to their index
    run_scrub();
    wait_scrub();
    send_req(0, SIZE_WORD, 0, 10'h010, 0);
    send_req(0, SIZE_WORD, 0, 10'h040, 0);
    send_req(0, SIZE_WORD, 0, 10'h3FC, 0);
    send_req(0, SIZE_WORD, 0, 10'h048, 0);  // Never stored
    wait_drain();

    // 5 loads queued behind a running scrub
    send_req(1, SIZE_WORD, 0, 10'h078, 32'hCAFE_F00D);
    wait_drain();
    run_scrub();
    send_req(0, SIZE_WORD, 0, 10'h078, 0);
    send_req(0, SIZE_BYTE, 0, 10'h07B, 0);
    send_req(0, SIZE_HALF, 1, 10'h07A, 0);
    send_req(0, SIZE_WORD, 0, 10'h07C, 0);
    check_val("o_scrub_busy", o_scrub_busy, 1);  // All sent inside the walk
    wait_scrub();
    wait_drain();
    check_val("credits returned", credit_pulses, sent);

    // 6 random mix under credit limits
    for (int n = 0; n < 200; n++) begin
      rnd = $urandom;
      if (rnd[8]) begin
        send_req(1, SIZE_WORD, 0, {rnd[7:0], 2'b00}, $urandom);
      end else begin
        case (rnd[10:9])
          2'd0: begin
            sz  = SIZE_BYTE;
            off = rnd[12:11];
          end
          2'd1: begin
            sz  = SIZE_HALF;
            off = {rnd[11], 1'b0};
          end
          default: begin
            sz  = SIZE_WORD;
            off = 2'b00;
          end
        endcase
        send_req(0, sz, rnd[13], {rnd[7:0], off}, 0);
      end
    end
    wait_drain();
    check_val("credits returned", credit_pulses, sent);

    $display("checks=%0d errors=%0d requests=%0d", checks, errors, sent);
    if (errors == 0) $display("=== PASS ===");
    else $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+.
mem_access_pkg.sv
mem_scrub_pkg.sv
req_queue.sv
data_memory.sv
dirty_tracker.sv
load_formatter.sv
mem_stage_top.sv
tb_mem_stage.sv

// File: Makefile
TOP = tb_mem_stage

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "=== FAIL ===" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" sim.log || (echo "Simulation ended without a result"; exit 1)

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
